/* common/fetch_cfg.svh */
// Size settings for the fetch front end. FETCH_BANKS and BANK_WORDS must be powers of two,
// with at least two banks; QUEUE_MARGIN must stay below QUEUE_DEPTH.
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// interleaved instruction banks, selected by word address bits
`define FETCH_BANKS 4

// words held by each bank
`define BANK_WORDS 64

// entries in the instruction queue
`define QUEUE_DEPTH 8

// almost full once free entries drop to this many
// one in-flight fetch needs at least one spare entry
`define QUEUE_MARGIN 2

`endif

/* common/fetch_pkg.sv */
// Types and encodings for the fetch front end; RV32 only, little-endian words as stored.
// Word addresses are byte addresses with the low two bits assumed zero.
package fetch_pkg;

	localparam int XLEN = 32;

	// byte address of an instruction
	typedef logic [XLEN-1:0] addr_t;

	// one raw instruction word
	typedef logic [XLEN-1:0] instr_t;

	// controller states
	// HALT is the boot state, left only by go
	typedef enum logic [1:0] {
		HALT,
		FETCH,
		WAIT_ROOM,
		ECALL_WAIT
	} fetch_state_t;

	// ecall: SYSTEM opcode with all other fields zero
	localparam instr_t ECALL_WORD = 32'h0000_0073;

	// addi x0, x0, 0
	localparam instr_t NOP_WORD = 32'h0000_0013;

	// sequential step between instruction addresses
	localparam addr_t PC_STEP = 32'd4;

endpackage : fetch_pkg

/* hw/instr_bank/instr_bank.sv */
// One word-interleaved instruction bank, Wishbone classic read slave plus a load write port.
// Upper address bits beyond the bank depth are ignored, so addresses alias.
`timescale 1ns/1ps

`include "fetch_cfg.svh"

module instr_bank #(
	parameter int BANK_INDEX = 0
) (
	input	logic				clk,
	input	logic				rst_n,

	// wishbone slave side
	input	logic				wb_cyc,
	input	logic				wb_stb,
	input	fetch_pkg::addr_t	wb_adr,
	output	logic				wb_ack,
	output	fetch_pkg::instr_t	wb_dat,

	// program load port
	input	logic				load_en,
	input	fetch_pkg::addr_t	load_addr,
	input	fetch_pkg::instr_t	load_data
);

	import fetch_pkg::*;

	localparam int SEL_W = $clog2(`FETCH_BANKS);
	localparam int WORD_W = $clog2(`BANK_WORDS);

	instr_t				mem [`BANK_WORDS];
	instr_t				rd_data;
	logic				bus_sel;
	logic				load_sel;
	logic [WORD_W-1:0]	bus_word;
	logic [WORD_W-1:0]	load_word;

	// bank field sits right above the byte offset
	assign bus_sel   = wb_cyc && wb_stb && (wb_adr[SEL_W+1:2] == SEL_W'(BANK_INDEX));
	assign load_sel  = load_en && (load_addr[SEL_W+1:2] == SEL_W'(BANK_INDEX));
	assign bus_word  = wb_adr[SEL_W+2 +: WORD_W];
	assign load_word = load_addr[SEL_W+2 +: WORD_W];

	// single-cycle ack, one cycle after stb is first seen
	always_ff @(posedge clk or negedge rst_n) begin
		if (~rst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= bus_sel & ~wb_ack;
	end

	always_ff @(posedge clk) begin
		if (bus_sel)
			rd_data <= mem[bus_word];
		if (load_sel)
			mem[load_word] <= load_data;
	end

	// zero when not acking so the top can OR all banks
	assign wb_dat = wb_ack ? rd_data : '0;

endmodule : instr_bank

/* hw/fetch/fetch_ctrl.sv */
// Fetch controller and Wishbone classic read master; one word per bus cycle, no pipelining.
// Assumes redirect_pc and boot_pc are word aligned.
`timescale 1ns/1ps

module fetch_ctrl (
	input	logic				clk,
	input	logic				rst_n,

	input	logic				go,
	input	logic				redirect,
	input	fetch_pkg::addr_t	redirect_pc,
	input	fetch_pkg::addr_t	boot_pc,

	// wishbone master side
	output	logic				wb_cyc,
	output	logic				wb_stb,
	output	fetch_pkg::addr_t	wb_adr,
	input	logic				wb_ack,
	input	fetch_pkg::instr_t	wb_dat,

	// instruction queue side
	output	logic				q_push,
	output	fetch_pkg::instr_t	q_word,
	output	fetch_pkg::addr_t	q_pc,
	output	logic				q_flush,
	input	logic				q_almost_full,

	output	logic				halted
);

	import fetch_pkg::*;

	fetch_state_t	state;
	addr_t			pc;
	addr_t			start_pc;
	logic			bus_busy;
	logic			stale;
	logic			accept;
	logic			is_ecall;

	// cyc and stb rise and fall together, reads only
	assign wb_cyc = bus_busy;
	assign wb_stb = bus_busy;

	// a word counts only if no redirect hit its bus cycle
	assign accept   = bus_busy & wb_ack & ~stale & ~redirect;
	assign is_ecall = (wb_dat == ECALL_WORD);

	// a redirect in the start cycle already steers the new fetch
	assign start_pc = redirect ? redirect_pc : pc;

	assign q_push  = accept;
	assign q_word  = wb_dat;
	assign q_pc    = wb_adr;
	assign q_flush = redirect;

	assign halted = (state == HALT) || (state == ECALL_WAIT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (~rst_n) begin
			state    <= HALT;
			pc       <= boot_pc;
			wb_adr   <= '0;
			bus_busy <= 1'b0;
			stale    <= 1'b0;
		end else begin
			// ack ends the bus cycle, stb drops on this edge
			if (bus_busy && wb_ack) begin
				bus_busy <= 1'b0;
				stale    <= 1'b0;
			end

			// pc update, redirect wins over the sequential step
			if (redirect) begin
				pc <= redirect_pc;
				// word of the running cycle is dropped when it arrives
				if (bus_busy && !wb_ack)
					stale <= 1'b1;
			end else if (accept) begin
				pc <= wb_adr + PC_STEP;
			end

			unique case (state)
				HALT, ECALL_WAIT: begin
					if (go) begin
						state    <= FETCH;
						bus_busy <= 1'b1;
						wb_adr   <= start_pc;
					end
				end

				FETCH: begin
					if (accept && is_ecall) begin
						// ecall word is queued, then wait for go
						state <= ECALL_WAIT;
					end else if (!bus_busy) begin
						// gap cycle: either start the next read or back off
						if (q_almost_full) begin
							state <= WAIT_ROOM;
						end else begin
							bus_busy <= 1'b1;
							wb_adr   <= start_pc;
						end
					end
				end

				WAIT_ROOM: begin
					// bus is idle here, resume as soon as room returns
					if (!q_almost_full) begin
						state    <= FETCH;
						bus_busy <= 1'b1;
						wb_adr   <= start_pc;
					end
				end

				default: begin
					state <= HALT;
				end
			endcase
		end
	end

endmodule : fetch_ctrl

/* hw/fetch/instr_queue.sv */
// In-order queue of instruction word and pc pairs between fetch and decode.
// A push into a full queue is dropped, so the writer must respect almost_full.
`timescale 1ns/1ps

`include "fetch_cfg.svh"

module instr_queue (
	input	logic				clk,
	input	logic				rst_n,

	// write side, from the fetch controller
	input	logic				push,
	input	fetch_pkg::instr_t	push_word,
	input	fetch_pkg::addr_t	push_pc,
	input	logic				flush,
	output	logic				almost_full,

	// decode side
	output	fetch_pkg::instr_t	instr,
	output	fetch_pkg::addr_t	pc_out,
	output	logic				instr_valid,
	input	logic				instr_ready
);

	import fetch_pkg::*;

	localparam int DEPTH = `QUEUE_DEPTH;
	localparam int MARGIN = `QUEUE_MARGIN;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	instr_t				word_mem [DEPTH];
	addr_t				pc_mem [DEPTH];
	logic [PTR_W-1:0]	wr_ptr;
	logic [PTR_W-1:0]	rd_ptr;
	logic [CNT_W-1:0]	count;
	logic				full;
	logic				push_ok;
	logic				pop;

	assign full        = (count == CNT_W'(DEPTH));
	assign instr_valid = (count != '0);
	assign push_ok     = push & ~full;
	assign pop         = instr_valid & instr_ready;

	// free entries at or below the margin
	assign almost_full = (DEPTH - int'(count)) <= MARGIN;

	// head entry, or a harmless nop while empty
	assign instr  = instr_valid ? word_mem[rd_ptr] : NOP_WORD;
	assign pc_out = instr_valid ? pc_mem[rd_ptr] : '0;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// storage
	always_ff @(posedge clk) begin
		if (push_ok) begin
			word_mem[wr_ptr] <= push_word;
			pc_mem[wr_ptr]   <= push_pc;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (~rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			// flush beats a push in the same cycle
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			if (push_ok && !pop)
				count <= count + 1'b1;
			else if (pop && !push_ok)
				count <= count - 1'b1;
		end
	end

endmodule : instr_queue

/* hw/fetch_top.sv */
// Fetch front end top: controller, interleaved banks and instruction queue.
// The load port writes only while halted is high.
`timescale 1ns/1ps

`include "fetch_cfg.svh"

module fetch_top (
	input	logic				clk,
	input	logic				rst_n,

	input	logic				go,
	input	logic				redirect,
	input	fetch_pkg::addr_t	redirect_pc,
	input	fetch_pkg::addr_t	boot_pc,

	input	logic				load_en,
	input	fetch_pkg::addr_t	load_addr,
	input	fetch_pkg::instr_t	load_data,

	output	fetch_pkg::instr_t	instr,
	output	fetch_pkg::addr_t	pc_out,
	output	logic				instr_valid,
	input	logic				instr_ready,
	output	logic				halted
);

	import fetch_pkg::*;

	logic						wb_cyc;
	logic						wb_stb;
	addr_t						wb_adr;
	logic						wb_ack;
	instr_t						wb_dat;
	logic [`FETCH_BANKS-1:0]	bank_ack;
	instr_t						bank_dat [`FETCH_BANKS];
	logic						load_we;

	logic						q_push;
	instr_t						q_word;
	addr_t						q_pc;
	logic						q_flush;
	logic						q_almost_full;

	fetch_ctrl u_ctrl (
		.clk			(clk),
		.rst_n			(rst_n),
		.go				(go),
		.redirect		(redirect),
		.redirect_pc	(redirect_pc),
		.boot_pc		(boot_pc),
		.wb_cyc			(wb_cyc),
		.wb_stb			(wb_stb),
		.wb_adr			(wb_adr),
		.wb_ack			(wb_ack),
		.wb_dat			(wb_dat),
		.q_push			(q_push),
		.q_word			(q_word),
		.q_pc			(q_pc),
		.q_flush		(q_flush),
		.q_almost_full	(q_almost_full),
		.halted			(halted)
	);

	// program loads only while no fetch runs
	assign load_we = load_en & halted;

	for (genvar b = 0; b < `FETCH_BANKS; b++) begin : g_bank
		instr_bank #(
			.BANK_INDEX	(b)
		) u_bank (
			.clk		(clk),
			.rst_n		(rst_n),
			.wb_cyc		(wb_cyc),
			.wb_stb		(wb_stb),
			.wb_adr		(wb_adr),
			.wb_ack		(bank_ack[b]),
			.wb_dat		(bank_dat[b]),
			.load_en	(load_we),
			.load_addr	(load_addr),
			.load_data	(load_data)
		);
	end

	// idle banks drive zero, so a plain OR selects the answer
	assign wb_ack = |bank_ack;

	always_comb begin
		wb_dat = '0;
		for (int b = 0; b < `FETCH_BANKS; b++)
			wb_dat = wb_dat | bank_dat[b];
	end

	instr_queue u_queue (
		.clk			(clk),
		.rst_n			(rst_n),
		.push			(q_push),
		.push_word		(q_word),
		.push_pc		(q_pc),
		.flush			(q_flush),
		.almost_full	(q_almost_full),
		.instr			(instr),
		.pc_out			(pc_out),
		.instr_valid	(instr_valid),
		.instr_ready	(instr_ready)
	);

endmodule : fetch_top

/* testbench/fetch_asserts.sv */
// Checks on the fetch Wishbone handshake and the instruction queue, bound twice.
// Ports a bind target does not have are tied to constants there.
`timescale 1ns/1ps

module fetch_asserts (
	input	logic				clk,
	input	logic				rst_n,
	input	logic				wb_stb,
	input	logic				wb_ack,
	input	fetch_pkg::addr_t	wb_adr,
	input	logic				halted,
	input	logic				push,
	input	logic				full
);

	int fail_count = 0;

	// strobe and address hold until the slave answers
	stb_held: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
		else begin
			$error("stb dropped or address moved before ack");
			fail_count++;
		end

	ack_single: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else begin
			$error("ack held for more than one cycle");
			fail_count++;
		end

	no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(push && full))
		else begin
			$error("push into a full instruction queue");
			fail_count++;
		end

	halted_idle: assert property (@(posedge clk) disable iff (!rst_n)
		halted |-> !wb_stb)
		else begin
			$error("stb raised while halted");
			fail_count++;
		end

endmodule : fetch_asserts

bind fetch_ctrl fetch_asserts ctrl_checks (
	.clk	(clk),
	.rst_n	(rst_n),
	.wb_stb	(wb_stb),
	.wb_ack	(wb_ack),
	.wb_adr	(wb_adr),
	.halted	(halted),
	.push	(1'b0),
	.full	(1'b0)
);

bind instr_queue fetch_asserts queue_checks (
	.clk	(clk),
	.rst_n	(rst_n),
	.wb_stb	(1'b0),
	.wb_ack	(1'b0),
	.wb_adr	('0),
	.halted	(1'b0),
	.push	(push),
	.full	(full)
);

/* testbench/fetch_tb.sv */
// Testbench for fetch_top, driven by the record file testbench/fetch_stimulus.hex.
// Run from the project root; each go test must end on an ecall word of the image.
`timescale 1ns/1ps

`include "fetch_cfg.svh"

module fetch_tb;

	import fetch_pkg::*;

	localparam int IMG_WORDS = `FETCH_BANKS * `BANK_WORDS;
	localparam int STIM_WORDS = 256;
	localparam int IDLE_CYCLES = 30;
	localparam int QUIET_CYCLES = 20;

	logic			clk;
	logic			rst_n;
	logic			go;
	logic			redirect;
	addr_t			redirect_pc;
	addr_t			boot_pc;
	logic			load_en;
	addr_t			load_addr;
	instr_t			load_data;
	instr_t			instr;
	addr_t			pc_out;
	logic			instr_valid;
	logic			instr_ready;
	logic			halted;

	logic [31:0]	stim [STIM_WORDS];
	instr_t			image [IMG_WORDS];
	integer			seed;
	int				errors;
	int				taken;
	int				checked;
	logic			stream_open;
	logic			redir_pending;
	addr_t			exp_pc;

	fetch_top dut (
		.clk			(clk),
		.rst_n			(rst_n),
		.go				(go),
		.redirect		(redirect),
		.redirect_pc	(redirect_pc),
		.boot_pc		(boot_pc),
		.load_en		(load_en),
		.load_addr		(load_addr),
		.load_data		(load_data),
		.instr			(instr),
		.pc_out			(pc_out),
		.instr_valid	(instr_valid),
		.instr_ready	(instr_ready),
		.halted			(halted)
	);

	always #10 clk = ~clk;

	// word slot of a byte address in the whole interleaved image
	function automatic int img_index(input addr_t a);
		return int'((a >> 2) % IMG_WORDS);
	endfunction

	// upper half never reads as an ecall for addresses below 64 KiB
	function automatic instr_t fill_word(input addr_t a);
		return {a[15:0] ^ 16'h5a5a, a[31:16] ^ a[15:0]};
	endfunction

	task automatic compare_instr(input string name, input instr_t got, input instr_t exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic compare_pc(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic note_failure(input string what);
		$display("error: %s at %0t", what, $time);
		errors++;
	endtask

	// next rising edge plus the input drive delay
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic load_word(input addr_t a, input instr_t d);
		load_en = 1'b1;
		load_addr = a;
		load_data = d;
		image[img_index(a)] = d;
		step();
		load_en = 1'b0;
	endtask

	// decode side sampled mid-cycle where everything is settled
	always @(negedge clk) begin
		if (stream_open && instr_valid && instr_ready) begin
			compare_pc("pc_out", pc_out, exp_pc);
			compare_instr("instr", instr, image[img_index(exp_pc)]);
			checked++;
			if (!redir_pending)
				taken++;
			exp_pc = exp_pc + PC_STEP;
		end
		// words after the redirect cycle must follow the new path
		if (stream_open && redirect) begin
			redir_pending = 1'b0;
			exp_pc = redirect_pc;
		end
	end

	task automatic run_test(input int num, input logic do_go, input int redir_cyc,
			input addr_t target, input logic rand_ready, input int count);
		int		start_errors;
		int		cyc;
		integer	rnd;
		addr_t	first_pc;
		start_errors = errors;
		first_pc = exp_pc;
		if (do_go) begin
			taken = 0;
			cyc = 0;
			redir_pending = (redir_cyc != 0);
			redirect_pc = target;
			stream_open = 1'b1;
			while (cyc == 0 || taken < count) begin
				go = (cyc == 0);
				redirect = (redir_cyc != 0) && (cyc == redir_cyc);
				if (rand_ready) begin
					rnd = $random(seed);
					instr_ready = rnd[0];
				end else begin
					instr_ready = 1'b1;
				end
				step();
				cyc++;
			end
			go = 1'b0;
			redirect = 1'b0;
			instr_ready = 1'b1;
			stream_open = 1'b0;
		end
		// nothing may come out while halted
		repeat (do_go ? QUIET_CYCLES : IDLE_CYCLES) begin
			@(negedge clk);
			compare_flag("instr_valid", instr_valid, 1'b0);
			compare_flag("halted", halted, 1'b1);
			// an empty queue shows a nop at pc zero
			compare_instr("instr", instr, NOP_WORD);
			compare_pc("pc_out", pc_out, '0);
		end
		step();
		$display("test %0d %s: start pc %h, %0d words, %0d errors", num,
			(errors == start_errors) ? "passed" : "failed", first_pc, count,
			errors - start_errors);
	endtask

	initial begin
		int		idx;
		int		i;
		int		tests;
		int		loads;
		int		words;
		int		budget;
		clk = 1'b0;
		rst_n = 1'b0;
		go = 1'b0;
		redirect = 1'b0;
		redirect_pc = '0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		instr_ready = 1'b1;
		seed = 32'h2f365f53;
		errors = 0;
		checked = 0;
		taken = 0;
		stream_open = 1'b0;
		redir_pending = 1'b0;
		$readmemh("testbench/fetch_stimulus.hex", stim);
		boot_pc = stim[0];
		exp_pc = stim[0];

		// watchdog allows 40 cycles per word plus 200 and the loads and quiet windows
		idx = 1;
		tests = 0;
		loads = 0;
		words = 0;
		budget = 200 + 16 + IMG_WORDS;
		while (idx < STIM_WORDS - 6 && (stim[idx] == 1 || stim[idx] == 2)) begin
			if (stim[idx] == 1) begin
				loads++;
				idx += 3;
			end else begin
				tests++;
				words += int'(stim[idx+5]);
				budget += int'(stim[idx+2]) + IDLE_CYCLES + 2;
				idx += 6;
			end
		end
		budget += 40 * words + 2 * loads;
		fork
			begin
				repeat (budget) @(posedge clk);
				$display("timeout: the DUT did not deliver all words within %0d cycles",
					budget);
				$display("TEST FAILED");
				$finish;
			end
		join_none

		repeat (16) step();
		rst_n = 1'b1;
		for (i = 0; i < IMG_WORDS; i++)
			load_word(addr_t'(i * 4), fill_word(addr_t'(i * 4)));

		idx = 1;
		tests = 0;
		while (idx < STIM_WORDS - 6 && (stim[idx] == 1 || stim[idx] == 2)) begin
			if (stim[idx] == 1) begin
				load_word(stim[idx+1], stim[idx+2]);
				idx += 3;
			end else begin
				tests++;
				run_test(tests, stim[idx+1][0], int'(stim[idx+2]), stim[idx+3],
					stim[idx+4][0], int'(stim[idx+5]));
				idx += 6;
			end
		end
		if (stim[idx] !== 32'h0 || tests == 0)
			note_failure("the stimulus file has a bad record or no test");

		errors += dut.u_ctrl.ctrl_checks.fail_count;
		errors += dut.u_queue.queue_checks.fail_count;
		$display("%0d tests, %0d words checked, %0d errors", tests, checked, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule : fetch_tb

/* testbench/fetch_stimulus.hex */
// word 0: boot pc; then records: 1 addr data = program load
// 2 go redirect_cycle redirect_pc random_ready expected_words = test; 0 ends the list
00000040
// boot program, ends on an ecall at 0x68
1 00000040 00100093
1 00000044 00200113
1 00000048 002081b3
1 0000004c 40208233
1 00000050 0020c2b3
1 00000054 00209313
1 00000058 0020d393
1 0000005c 00112423
1 00000060 00812483
1 00000064 00000013
1 00000068 00000073
// second block, filler words in between, ecall at 0xa4
1 0000006c 00300513
1 00000070 00a50533
1 000000a4 00000073
// redirect target, ecall at 0x210
1 00000200 0ff00613
1 00000204 00c60633
1 00000208 fff60613
1 0000020c 00000013
1 00000210 00000073
// block for the reload test, ecall at 0x220
1 00000218 00500593
1 0000021c 00b58633
1 00000220 00000073
// no go: halted, nothing valid
2 0 0 00000000 0 0
// sequential fetch from boot pc
2 1 0 00000000 0 0b
// resume after ecall with random ready
2 1 0 00000000 1 0f
// redirect on cycle 14 to 0x200
2 1 0e 00000200 0 5
// reload one word while halted
1 00000218 00a00593
2 1 0 00000000 1 4
// redirect with random ready back to boot program
2 1 9 00000040 1 0b
0

/* compile.f */
+incdir+common
common/fetch_pkg.sv
hw/instr_bank/instr_bank.sv
hw/fetch/fetch_ctrl.sv
hw/fetch/instr_queue.sv
hw/fetch_top.sv
testbench/fetch_asserts.sv
testbench/fetch_tb.sv

/* Makefile */
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP ?= fetch_tb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
JOBS ?= 4
VFLAGS ?= --binary --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
